// ==== testbench/clock_stimulus.txt ====
# press <button> <count> | wait <seconds> | expect_time <test> <hh> <mm> <ss>
# expect_alarm <test> <bit>; waits count from the previous wait mark
wait 0
expect_time reset_display 0 0 0
expect_alarm reset_alarm 0
wait 125
expect_time minute_carry 0 2 5
press mode 1
wait 3
expect_time set_frozen 0 2 5
press pos 1
press adj 56
expect_time set_min_58 0 58 5
press adj 3
expect_time set_min_wrap 0 1 5
press pos 1
press adj 23
expect_time set_hr_23 23 1 5
press adj 1
expect_time set_hr_wrap 0 1 5
wait 40
expect_time set_still_frozen 0 1 5
press mode 1
press pos 1
press adj 10
expect_time alarm_sec 0 0 10
press pos 1
press adj 1
expect_time alarm_min 0 1 10
press pos 2
press adj 12
wait 13
expect_time alarm_shown 0 1 22
press mode 1
press alarm 1
wait 1
expect_time time_kept_running 0 1 19
expect_alarm alarm_before_match 0
wait 3
expect_alarm alarm_after_match 1
expect_time alarm_match_time 0 1 22
press alarm 1
wait 1
expect_alarm alarm_disabled 0
expect_time after_disable 0 1 23
press mode 1
press adj 35
press pos 1
press adj 58
press pos 1
press adj 23
wait 46
expect_time set_end_of_day 23 59 58
press mode 2
wait 2
expect_time day_wrap 0 0 0

// ==== tb.f ====
hdl/clock_pkg.sv
hdl/count_ctrl_if.sv
hdl/button_sync.sv
hdl/clock_ctrl.sv
hdl/timekeeper.sv
hdl/display_scan.sv
hdl/digital_clock.sv
testbench/digital_clock_assertions.sv
testbench/tb_digital_clock.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, result taken from sim.log

verilator --binary --timing --assert --top-module tb_digital_clock -f tb.f -o sim_tb \
	> sim.log 2>&1 && ./obj_dir/sim_tb >> sim.log 2>&1 || echo "build or run error" >> sim.log

cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

// ==== testbench/tb_digital_clock.sv ====
`timescale 1ns/1ps

module tb_digital_clock;

	import clock_pkg::*;

	localparam string STIM_FILE   = "testbench/clock_stimulus.txt";
	localparam int    PRESS_MAX   = 25;	// lead-in edge, 4 hold, up to 20 gap
	localparam int    READ_CYCLES = NUM_DIGITS * SCAN_DIV + SCAN_DIV + 2;

	logic        clk;
	logic        rst_n;
	logic [3:0]  btn;	// {alarm, adj, pos, mode}
	seg_t        o_seg;
	seg_enb_t    o_seg_enb;
	logic        o_alarm;
	int unsigned cyc;	// clk edges since reset release
	int          limit_cycles;

	digital_clock dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn[0]),
		.i_btn_pos   (btn[1]),
		.i_btn_adj   (btn[2]),
		.i_btn_alarm (btn[3]),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb),
		.o_alarm     (o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cyc <= cyc + 1;
		end else begin
			cyc <= 0;
		end
	end

	// ----------------------------------------
	// failure and compare tasks
	// ----------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_field(input string name, input field_t expected, input field_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
			fail_run("displayed field differs from the expected value");
		end
	endtask

	task automatic check_seg_enb(input string name, input seg_enb_t expected,
			input seg_enb_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			fail_run("digit enable out of scan order");
		end
	endtask

	task automatic check_alarm(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			fail_run("alarm output differs from the expected value");
		end
	endtask

	// ----------------------------------------
	// display decoding
	// ----------------------------------------
	function automatic seg_enb_t enb_for_digit(input int idx);
		seg_enb_t enb;
		enb = '1;
		enb[idx] = 1'b0;	// only this digit on
		return enb;
	endfunction

	function automatic int enb_index(input seg_enb_t enb);
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (enb === enb_for_digit(i)) return i;
		end
		return -1;
	endfunction

	function automatic int seg_to_digit(input seg_t seg);
		for (int i = 0; i < 10; i++) begin
			if (seg === SEG_CODE[i]) return i;
		end
		return -1;
	endfunction

	task automatic read_display(input string name, output field_t hr, output field_t mn,
			output field_t sc);
		seg_enb_t prev_enb;
		int       start;
		int       idx;
		int       d;
		int       k;
		int       dig [NUM_DIGITS];
		@(negedge clk);
		prev_enb = o_seg_enb;
		k = 0;
		// find the first cycle of a digit
		do begin
			@(negedge clk);
			k++;
			if (k > SCAN_DIV) fail_run("display scan does not advance");
		end while (o_seg_enb === prev_enb);
		start = enb_index(o_seg_enb);
		for (k = 0; k < NUM_DIGITS * SCAN_DIV; k++) begin
			if (k > 0) @(negedge clk);
			if (enb_index(o_seg_enb) < 0) fail_run("illegal digit enable pattern");
			idx = (start + k / SCAN_DIV) % NUM_DIGITS;
			check_seg_enb(name, enb_for_digit(idx), o_seg_enb);
			d = seg_to_digit(o_seg);
			if (d < 0) fail_run("illegal segment pattern on the display");
			dig[idx] = d;
		end
		sc = field_t'(dig[1] * 10 + dig[0]);
		mn = field_t'(dig[3] * 10 + dig[2]);
		hr = field_t'(dig[5] * 10 + dig[4]);
	endtask

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	task automatic press_button(input int idx);
		@(negedge clk);
		btn[idx] = 1'b1;
		repeat (4) @(negedge clk);
		btn[idx] = 1'b0;
		repeat ($urandom_range(20, 6)) @(negedge clk);
	endtask

	function automatic int button_index(input string name);
		case (name)
			"mode":  return 0;
			"pos":   return 1;
			"adj":   return 2;
			"alarm": return 3;
			default: return -1;
		endcase
	endfunction

	// rough run length from the file, in cycles
	function automatic int estimate_cycles();
		int    fd;
		int    n;
		int    total;
		string line;
		string cmd;
		string arg;
		total = 16 + TICKS_PER_SEC;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) return 0;
		while ($fgets(line, fd) != 0) begin
			n = 0;
			if (line.len() < 2 || line.substr(0, 0) == "#") continue;
			void'($sscanf(line, "%s", cmd));
			if (cmd == "wait") begin
				void'($sscanf(line, "%s %d", cmd, n));
				total += n * TICKS_PER_SEC;
			end else if (cmd == "press") begin
				void'($sscanf(line, "%s %s %d", cmd, arg, n));
				total += n * PRESS_MAX;
			end else begin
				total += READ_CYCLES;
			end
		end
		$fclose(fd);
		return total + total / 2;
	endfunction

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, run exceeded %0d cycles", limit_cycles);
		$display("Simulation failed");
		$fatal(1);
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin : main
		int          fd;
		int          n;
		int          a;
		int          b;
		int          c;
		int unsigned target;
		string       line;
		string       cmd;
		string       arg;
		field_t      hr;
		field_t      mn;
		field_t      sc;
		rst_n = 1'b0;
		btn   = '0;
		limit_cycles = 0;
		void'($urandom(58663));
		n = estimate_cycles();
		if (n == 0) fail_run("cannot open the stimulus file");
		limit_cycles = n;
		repeat (16) @(negedge clk);
		rst_n  = 1'b1;
		target = TICKS_PER_SEC / 2;	// half a second, away from any tick
		fd = $fopen(STIM_FILE, "r");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.substr(0, 0) == "#") continue;
			void'($sscanf(line, "%s", cmd));
			if (cmd == "press") begin
				void'($sscanf(line, "%s %s %d", cmd, arg, a));
				if (button_index(arg) < 0) fail_run("unknown button in the stimulus file");
				repeat (a) press_button(button_index(arg));
			end else if (cmd == "wait") begin
				void'($sscanf(line, "%s %d", cmd, a));
				target += a * TICKS_PER_SEC;	// waits count from the last mark
				if (cyc > target) fail_run("stimulus ran past its wait time");
				while (cyc < target) @(negedge clk);
			end else if (cmd == "expect_time") begin
				void'($sscanf(line, "%s %s %d %d %d", cmd, arg, a, b, c));
				read_display(arg, hr, mn, sc);
				check_field({arg, "_hr"}, field_t'(a), hr);
				check_field({arg, "_min"}, field_t'(b), mn);
				check_field({arg, "_sec"}, field_t'(c), sc);
			end else if (cmd == "expect_alarm") begin
				void'($sscanf(line, "%s %s %d", cmd, arg, a));
				@(negedge clk);
				check_alarm(arg, a[0], o_alarm);
			end else begin
				fail_run("unknown command in the stimulus file");
			end
		end
		$fclose(fd);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== testbench/digital_clock_assertions.sv ====
`timescale 1ns/1ps

module digital_clock_assertions (
	input logic              clk,
	input logic              rst_n,
	input clock_pkg::field_t sec,
	input clock_pkg::field_t min,
	input clock_pkg::field_t hr,
	input clock_pkg::field_t al_sec,
	input clock_pkg::field_t al_min,
	input clock_pkg::field_t al_hr,
	input logic              inc_sec,
	input logic              inc_min,
	input logic              inc_hr,
	input logic              sec_wrap,
	input logic              min_wrap,
	input logic              alarm_en,
	input logic              alarm
);

	import clock_pkg::*;

	field_limits: assert property (@(posedge clk) disable iff (!rst_n)
		sec <= SEC_MAX && min <= MIN_MAX && hr <= HR_MAX &&
		al_sec <= SEC_MAX && al_min <= MIN_MAX && al_hr <= HR_MAX)
		else $error("a field is beyond its limit");

	// two strobes together only on a carry
	sec_min_carry: assert property (@(posedge clk) disable iff (!rst_n)
		(inc_sec && inc_min) |-> sec_wrap)
		else $error("seconds and minutes strobed without a carry");

	min_hr_carry: assert property (@(posedge clk) disable iff (!rst_n)
		(inc_min && inc_hr) |-> (min_wrap && inc_sec))
		else $error("minutes and hours strobed without a carry");

	alarm_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
		!alarm_en |=> !alarm)
		else $error("alarm high after the enable was low");

endmodule

bind timekeeper digital_clock_assertions assert_i (
	.clk      (clk),
	.rst_n    (rst_n),
	.sec      (o_sec),
	.min      (o_min),
	.hr       (o_hr),
	.al_sec   (o_al_sec),
	.al_min   (o_al_min),
	.al_hr    (o_al_hr),
	.inc_sec  (cnt.inc_sec),
	.inc_min  (cnt.inc_min),
	.inc_hr   (cnt.inc_hr),
	.sec_wrap (cnt.sec_wrap),
	.min_wrap (cnt.min_wrap),
	.alarm_en (i_alarm_en),
	.alarm    (o_alarm)
);

// ==== hdl/digital_clock.sv ====
`timescale 1ns/1ps

module digital_clock (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_btn_mode,
	input  logic                i_btn_pos,
	input  logic                i_btn_adj,
	input  logic                i_btn_alarm,
	output clock_pkg::seg_t     o_seg,
	output clock_pkg::seg_enb_t o_seg_enb,
	output logic                o_alarm
);

	import clock_pkg::*;

	logic [3:0] press;
	mode_t      mode;
	logic       alarm_en;
	field_t     sec;
	field_t     min;
	field_t     hr;
	field_t     al_sec;
	field_t     al_min;
	field_t     al_hr;

	count_ctrl_if cnt_if ();

	button_sync u_button_sync (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_btn   ({i_btn_alarm, i_btn_adj, i_btn_pos, i_btn_mode}),
		.o_press (press)
	);

	clock_ctrl u_clock_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_press    (press),
		.cnt        (cnt_if.ctrl),
		.o_mode     (mode),
		.o_alarm_en (alarm_en)
	);

	timekeeper u_timekeeper (
		.clk        (clk),
		.rst_n      (rst_n),
		.cnt        (cnt_if.keeper),
		.i_alarm_en (alarm_en),
		.o_sec      (sec),
		.o_min      (min),
		.o_hr       (hr),
		.o_al_sec   (al_sec),
		.o_al_min   (al_min),
		.o_al_hr    (al_hr),
		.o_alarm    (o_alarm)
	);

	display_scan u_display_scan (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_mode    (mode),
		.i_sec     (sec),
		.i_min     (min),
		.i_hr      (hr),
		.i_al_sec  (al_sec),
		.i_al_min  (al_min),
		.i_al_hr   (al_hr),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb)
	);

endmodule

// ==== hdl/display_scan.sv ====
`timescale 1ns/1ps

module display_scan (
	input  logic                clk,
	input  logic                rst_n,
	input  clock_pkg::mode_t    i_mode,
	input  clock_pkg::field_t   i_sec,
	input  clock_pkg::field_t   i_min,
	input  clock_pkg::field_t   i_hr,
	input  clock_pkg::field_t   i_al_sec,
	input  clock_pkg::field_t   i_al_min,
	input  clock_pkg::field_t   i_al_hr,
	output clock_pkg::seg_t     o_seg,
	output clock_pkg::seg_enb_t o_seg_enb
);

	import clock_pkg::*;

	logic [SCAN_W-1:0] scan_cnt;
	logic              scan_step;
	logic [DIG_W-1:0]  dig_idx;
	logic              show_alarm;
	field_t            show_sec;
	field_t            show_min;
	field_t            show_hr;
	field_t            field_sel;
	digit_t            digit;

	// ----------------------------------------
	// scan counter
	// ----------------------------------------
	assign scan_step = (scan_cnt == SCAN_W'(SCAN_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			scan_cnt <= '0;
			dig_idx  <= '0;
		end else if (scan_step) begin
			scan_cnt <= '0;
			if (dig_idx == DIG_W'(NUM_DIGITS - 1)) begin
				dig_idx <= '0;
			end else begin
				dig_idx <= dig_idx + 1'b1;
			end
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	assign o_seg_enb = ~(seg_enb_t'(1) << dig_idx);	// one digit low at a time

	// ----------------------------------------
	// field select and decode
	// ----------------------------------------
	assign show_alarm = (i_mode == mode_alarm);
	assign show_sec   = show_alarm ? i_al_sec : i_sec;
	assign show_min   = show_alarm ? i_al_min : i_min;
	assign show_hr    = show_alarm ? i_al_hr : i_hr;

	always_comb begin
		case (dig_idx)
			3'd0, 3'd1: field_sel = show_sec;
			3'd2, 3'd3: field_sel = show_min;
			default:    field_sel = show_hr;
		endcase
	end

	// odd index is the tens digit
	assign digit = dig_idx[0] ? digit_t'(field_sel / 10) : digit_t'(field_sel % 10);

	assign o_seg = (digit > 4'd9) ? '0 : SEG_CODE[digit];	// blank on a bad digit

endmodule

// ==== hdl/timekeeper.sv ====
`timescale 1ns/1ps

module timekeeper (
	input  logic              clk,
	input  logic              rst_n,
	count_ctrl_if.keeper      cnt,
	input  logic              i_alarm_en,
	output clock_pkg::field_t o_sec,
	output clock_pkg::field_t o_min,
	output clock_pkg::field_t o_hr,
	output clock_pkg::field_t o_al_sec,
	output clock_pkg::field_t o_al_min,
	output clock_pkg::field_t o_al_hr,
	output logic              o_alarm
);

	import clock_pkg::*;

	logic match;

	// next value of a field, wrapping after its last value
	function automatic field_t step(input field_t value, input field_t last);
		return (value == last) ? '0 : value + 1'b1;
	endfunction

	// ----------------------------------------
	// time counters
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_sec <= '0;
			o_min <= '0;
			o_hr  <= '0;
		end else begin
			if (cnt.inc_sec) o_sec <= step(o_sec, SEC_MAX);
			if (cnt.inc_min) o_min <= step(o_min, MIN_MAX);
			if (cnt.inc_hr)  o_hr  <= step(o_hr, HR_MAX);
		end
	end

	assign cnt.sec_wrap = (o_sec == SEC_MAX);
	assign cnt.min_wrap = (o_min == MIN_MAX);

	// ----------------------------------------
	// alarm counters
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_al_sec <= '0;
			o_al_min <= '0;
			o_al_hr  <= '0;
		end else begin
			if (cnt.inc_al_sec) o_al_sec <= step(o_al_sec, SEC_MAX);
			if (cnt.inc_al_min) o_al_min <= step(o_al_min, MIN_MAX);
			if (cnt.inc_al_hr)  o_al_hr  <= step(o_al_hr, HR_MAX);
		end
	end

	// match latch, held until the alarm is switched off
	assign match = (o_sec == o_al_sec) && (o_min == o_al_min) && (o_hr == o_al_hr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en && (o_alarm || match);
		end
	end

endmodule

// ==== hdl/clock_ctrl.sv ====
`timescale 1ns/1ps

module clock_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [3:0]       i_press,	// {alarm, adj, pos, mode}
	count_ctrl_if.ctrl       cnt,
	output clock_pkg::mode_t o_mode,
	output logic             o_alarm_en
);

	import clock_pkg::*;

	logic              press_mode;
	logic              press_pos;
	logic              press_adj;
	logic              press_alarm;
	pos_t              pos;
	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	logic              time_run;
	logic              carry_min;
	logic              carry_hr;
	logic              adj_set;
	logic              adj_alarm;

	assign press_mode  = i_press[0];
	assign press_pos   = i_press[1];
	assign press_adj   = i_press[2];
	assign press_alarm = i_press[3];

	// ----------------------------------------
	// mode, position, alarm enable
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_mode <= mode_clock;
		end else if (press_mode) begin
			case (o_mode)
				mode_clock: o_mode <= mode_set;
				mode_set:   o_mode <= mode_alarm;
				default:    o_mode <= mode_clock;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			pos <= pos_sec;
		end else if (press_pos) begin
			case (pos)
				pos_sec: pos <= pos_min;
				pos_min: pos <= pos_hr;
				default: pos <= pos_sec;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alarm_en <= 1'b0;
		end else if (press_alarm) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	// ----------------------------------------
	// one-second tick
	// ----------------------------------------
	assign tick = (tick_cnt == TICK_W'(TICKS_PER_SEC - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// strobe routing
	// ----------------------------------------
	assign time_run  = (o_mode != mode_set);	// set mode freezes the time
	assign carry_min = time_run && tick && cnt.sec_wrap;
	assign carry_hr  = carry_min && cnt.min_wrap;
	assign adj_set   = press_adj && (o_mode == mode_set);
	assign adj_alarm = press_adj && (o_mode == mode_alarm);

	// adjust steps one field only, no carry
	assign cnt.inc_sec = (time_run && tick) || (adj_set && (pos == pos_sec));
	assign cnt.inc_min = carry_min || (adj_set && (pos == pos_min));
	assign cnt.inc_hr  = carry_hr || (adj_set && (pos == pos_hr));

	assign cnt.inc_al_sec = adj_alarm && (pos == pos_sec);
	assign cnt.inc_al_min = adj_alarm && (pos == pos_min);
	assign cnt.inc_al_hr  = adj_alarm && (pos == pos_hr);

endmodule

// ==== hdl/button_sync.sv ====
`timescale 1ns/1ps

module button_sync (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:0] i_btn,
	output logic [3:0] o_press
);

	logic [3:0] sync_1;
	logic [3:0] sync_2;
	logic [3:0] level_d;	// previous synchronised level

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			sync_1  <= '0;
			sync_2  <= '0;
			level_d <= '0;
			o_press <= '0;
		end else begin
			sync_1  <= i_btn;
			sync_2  <= sync_1;
			level_d <= sync_2;
			// one pulse per rising level, however long the hold
			o_press <= sync_2 & ~level_d;
		end
	end

endmodule

// ==== hdl/count_ctrl_if.sv ====
`timescale 1ns/1ps

interface count_ctrl_if;

	logic inc_sec;
	logic inc_min;
	logic inc_hr;
	logic inc_al_sec;
	logic inc_al_min;
	logic inc_al_hr;
	logic sec_wrap;		// seconds at SEC_MAX
	logic min_wrap;		// minutes at MIN_MAX

	modport ctrl (
		output inc_sec, inc_min, inc_hr,
		output inc_al_sec, inc_al_min, inc_al_hr,
		input  sec_wrap, min_wrap
	);

	modport keeper (
		input  inc_sec, inc_min, inc_hr,
		input  inc_al_sec, inc_al_min, inc_al_hr,
		output sec_wrap, min_wrap
	);

endinterface

// ==== hdl/clock_pkg.sv ====
package clock_pkg;

	typedef logic [5:0] field_t;	// sec, min or hr value
	typedef logic [3:0] digit_t;	// one decimal digit
	typedef logic [6:0] seg_t;	// {a,b,c,d,e,f,g}, active high
	typedef logic [5:0] seg_enb_t;	// one bit per digit, active low

	typedef enum logic [1:0] {
		mode_clock,
		mode_set,
		mode_alarm
	} mode_t;

	typedef enum logic [1:0] {
		pos_sec,
		pos_min,
		pos_hr
	} pos_t;

	// last value before wrap to 0
	localparam field_t SEC_MAX = 6'd59;
	localparam field_t MIN_MAX = 6'd59;
	localparam field_t HR_MAX  = 6'd23;

	// ----------------------------------------
	// dividers, sized small for simulation
	// ----------------------------------------
	localparam int TICKS_PER_SEC = 64;
	localparam int SCAN_DIV      = 2;	// clk cycles per digit
	localparam int NUM_DIGITS    = 6;
	localparam int TICK_W        = $clog2(TICKS_PER_SEC);
	localparam int SCAN_W        = $clog2(SCAN_DIV);
	localparam int DIG_W         = $clog2(NUM_DIGITS);

	// digit 0 to 9
	localparam seg_t SEG_CODE [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

endpackage
